// ==== lsu.f ====
verilog/rv_isa_pkg.sv
verilog/lsu_pkg.sv
verilog/lsu_decode.sv
verilog/store_align.sv
verilog/load_align.sv
verilog/data_ram.sv
verilog/lsu_ctrl.sv
verilog/lsu_top.sv
sim/lsu_assert.sv
sim/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build the Verilator model of lsu_tb and run it, then look for the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module lsu_tb -f lsu.f -o lsu_sim \
    && ./obj_dir/lsu_sim > sim.log 2>&1 ; cat sim.log 2>/dev/null

grep -q "^sim passed$" sim.log \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

exit 0

// ==== sim/lsu_assert.sv ====
`timescale 1ns/1ps

module lsu_assert (
    input logic clk,
    input logic reset,
    input logic req,
    input logic ack,
    input logic mem_strobe,
    input logic mem_we
);

    // Ack only answers a pending request.
    ack_rise_with_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (reset)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // One write cycle per access.
    we_single_strobe: assert property (@(posedge clk) disable iff (reset)
        mem_we |=> !mem_strobe)
        else $error("RAM access strobe held after a write cycle");

endmodule

bind lsu_top lsu_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .ack        (ack),
    .mem_strobe (mem_strobe),
    .mem_we     (mem_we)
);

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;

    import lsu_pkg::*;
    import rv_isa_pkg::*;

    localparam int ADDR_WIDTH = 10;
    localparam int BYTE_AW = ADDR_WIDTH + 2;
    localparam int ACK_LATENCY = 2;
    localparam int NUM_PAIRS = 40;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] base;
        logic [31:0] sdata;
        logic [31:0] exp_rdata;
        logic        exp_err;
    } entry_t;

    logic     clk;
    logic     reset;
    logic     req;
    lsu_req_t request;
    logic     ack;
    lsu_rsp_t response;

    logic [7:0] ref_mem [2**BYTE_AW]; // Byte image of the RAM.
    entry_t     stim_table [$];
    integer     seed;
    int         cycle_count = 0;
    int         max_cycles = 0;

    lsu_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dut (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .request  (request),
        .ack      (ack),
        .response (response)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s: got %h, expected %h",
                     $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    // Raw RV32I encodings, rs1 = x1, rd/rs2 = x2.
    function automatic logic [31:0] load_inst(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd2, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_inst(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    task automatic add_entry(input logic [31:0] inst, input logic [31:0] base,
                             input logic [31:0] sdata, input logic [31:0] exp_rdata,
                             input logic exp_err);
        stim_table.push_back({inst, base, sdata, exp_rdata, exp_err});
    endtask

    // Reference model of one access, straight from the ISA rules.
    task automatic model_access(input logic [31:0] inst, input logic [31:0] base,
                                input logic [31:0] sdata, output logic [31:0] rdata,
                                output logic err);
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [31:0]        imm;
        logic [31:0]        addr;
        logic [31:0]        word;
        logic [BYTE_AW-1:0] idx;
        int                 nbytes;
        opc = inst[6:0];
        f3 = inst[14:12];
        word = '0;
        if (opc == 7'b0100011) begin
            imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        end else begin
            imm = {{20{inst[31]}}, inst[31:20]};
        end
        addr = base + imm;
        nbytes = (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
        if (opc == 7'b0000011) begin
            err = (f3[1:0] == 2'd3) || (f3 == 3'b110);
        end else if (opc == 7'b0100011) begin
            err = f3[2] || (f3[1:0] == 2'd3);
        end else begin
            err = 1'b1;
        end
        if ((addr & (nbytes - 1)) != 0) begin
            err = 1'b1; // Misaligned.
        end
        if (!err) begin
            for (int k = 0; k < nbytes; k++) begin
                idx = BYTE_AW'(addr + k);
                if (opc == 7'b0100011) begin
                    ref_mem[idx] = 8'(sdata >> (8 * k));
                end else begin
                    word = word | (32'(ref_mem[idx]) << (8 * k));
                end
            end
            if (opc == 7'b0000011 && !f3[2] && nbytes == 1) begin
                word = {{24{word[7]}}, word[7:0]};
            end else if (opc == 7'b0000011 && !f3[2] && nbytes == 2) begin
                word = {{16{word[15]}}, word[15:0]};
            end
        end
        rdata = (opc == 7'b0000011 && !err) ? word : 32'h0;
    endtask

    // One full four-phase handshake with a hold of extra cycles on req.
    task automatic run_transaction(input logic [31:0] inst, input logic [31:0] base,
                                   input logic [31:0] sdata, input int hold,
                                   output logic [31:0] rdata, output logic err);
        lsu_req_t r;
        int       waited;
        r = {inst, base, sdata};
        @(posedge clk);
        req <= 1'b1;
        request <= r;
        @(negedge clk);
        waited = 0;
        while (!ack) begin
            @(negedge clk);
            waited++;
        end
        check(waited - 1, ACK_LATENCY, "cycles from accepting edge to ack");
        rdata = response.rdata;
        err = response.err;
        repeat (hold) begin
            @(negedge clk);
            check(32'(ack), 32'd1, "ack held while req high");
            check(response.rdata, rdata, "response stable under back-pressure");
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check(32'(ack), 32'd1, "ack before the req drop is seen");
        @(negedge clk);
        check(32'(ack), 32'd0, "ack fall after req drop");
    endtask

    task automatic build_table();
        add_entry(store_inst(F3_SW, 12'h000), 32'h100, 32'h11223344, 32'h0, 1'b0);
        add_entry(load_inst(F3_LW, 12'h000), 32'h100, 32'h0, 32'h11223344, 1'b0);
        add_entry(store_inst(F3_SW, 12'hffc), 32'h108, 32'hdeadbeef, 32'h0, 1'b0);
        add_entry(load_inst(F3_LW, 12'h004), 32'h100, 32'h0, 32'hdeadbeef, 1'b0);
        // Byte lanes of word 0x110.
        add_entry(store_inst(F3_SW, 12'h010), 32'h100, 32'ha5a5a5a5, 32'h0, 1'b0);
        add_entry(store_inst(F3_SB, 12'h011), 32'h100, 32'hffffffc3, 32'h0, 1'b0);
        add_entry(load_inst(F3_LW, 12'h010), 32'h100, 32'h0, 32'ha5a5c3a5, 1'b0);
        add_entry(store_inst(F3_SB, 12'h013), 32'h100, 32'h123456f8, 32'h0, 1'b0);
        add_entry(load_inst(F3_LW, 12'h010), 32'h100, 32'h0, 32'hf8a5c3a5, 1'b0);
        add_entry(store_inst(F3_SB, 12'h010), 32'h100, 32'h0000009a, 32'h0, 1'b0);
        add_entry(store_inst(F3_SB, 12'h012), 32'h100, 32'h0000008f, 32'h0, 1'b0);
        add_entry(load_inst(F3_LW, 12'h010), 32'h100, 32'h0, 32'hf88fc39a, 1'b0);
        // Half-word lanes of word 0x120.
        add_entry(store_inst(F3_SW, 12'h020), 32'h100, 32'h00000000, 32'h0, 1'b0);
        add_entry(store_inst(F3_SH, 12'h022), 32'h100, 32'habcd8001, 32'h0, 1'b0);
        add_entry(load_inst(F3_LW, 12'h020), 32'h100, 32'h0, 32'h80010000, 1'b0);
        add_entry(store_inst(F3_SH, 12'h020), 32'h100, 32'h00009ffe, 32'h0, 1'b0);
        add_entry(load_inst(F3_LW, 12'h020), 32'h100, 32'h0, 32'h80019ffe, 1'b0);
        // Extension at every offset.
        add_entry(load_inst(F3_LB, 12'h010), 32'h100, 32'h0, 32'hffffff9a, 1'b0);
        add_entry(load_inst(F3_LBU, 12'h010), 32'h100, 32'h0, 32'h0000009a, 1'b0);
        add_entry(load_inst(F3_LB, 12'h011), 32'h100, 32'h0, 32'hffffffc3, 1'b0);
        add_entry(load_inst(F3_LBU, 12'h011), 32'h100, 32'h0, 32'h000000c3, 1'b0);
        add_entry(load_inst(F3_LB, 12'h012), 32'h100, 32'h0, 32'hffffff8f, 1'b0);
        add_entry(load_inst(F3_LBU, 12'h012), 32'h100, 32'h0, 32'h0000008f, 1'b0);
        add_entry(load_inst(F3_LB, 12'hfe3), 32'h130, 32'h0, 32'hfffffff8, 1'b0);
        add_entry(load_inst(F3_LBU, 12'h013), 32'h100, 32'h0, 32'h000000f8, 1'b0);
        add_entry(load_inst(F3_LH, 12'h020), 32'h100, 32'h0, 32'hffff9ffe, 1'b0);
        add_entry(load_inst(F3_LHU, 12'h020), 32'h100, 32'h0, 32'h00009ffe, 1'b0);
        add_entry(load_inst(F3_LH, 12'hf22), 32'h200, 32'h0, 32'hffff8001, 1'b0);
        add_entry(load_inst(F3_LHU, 12'h022), 32'h100, 32'h0, 32'h00008001, 1'b0);
        // Rejected accesses.
        add_entry(store_inst(F3_SH, 12'h021), 32'h100, 32'hffffffff, 32'h0, 1'b1);
        add_entry(store_inst(F3_SW, 12'h022), 32'h100, 32'hffffffff, 32'h0, 1'b1);
        add_entry(load_inst(F3_LH, 12'h023), 32'h100, 32'h0, 32'h0, 1'b1);
        add_entry(load_inst(F3_LW, 12'h011), 32'h100, 32'h0, 32'h0, 1'b1);
        add_entry(32'h00100093, 32'h100, 32'hffffffff, 32'h0, 1'b1); // ADDI.
        add_entry(load_inst(3'b011, 12'h000), 32'h100, 32'h0, 32'h0, 1'b1);
        add_entry(store_inst(3'b100, 12'h000), 32'h100, 32'hffffffff, 32'h0, 1'b1);
        add_entry(load_inst(F3_LW, 12'h020), 32'h100, 32'h0, 32'h80019ffe, 1'b0);
        add_entry(load_inst(F3_LW, 12'h010), 32'h100, 32'h0, 32'hf88fc39a, 1'b0);
        add_entry(load_inst(F3_LW, 12'h000), 32'h100, 32'h0, 32'h11223344, 1'b0);
    endtask

    initial begin
        entry_t      e;
        logic [31:0] rdata;
        logic        err;
        logic [31:0] m_rdata;
        logic        m_err;
        logic [31:0] addr;
        logic [31:0] imm;
        logic [31:0] data;
        reset = 1'b1;
        req = 1'b0;
        request = '0;
        seed = 32'hfca566ab;
        build_table();
        max_cycles = 10 * (stim_table.size() + 2 * NUM_PAIRS) * 6;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        foreach (stim_table[i]) begin
            e = stim_table[i];
            run_transaction(e.inst, e.base, e.sdata, i % 3, rdata, err);
            model_access(e.inst, e.base, e.sdata, m_rdata, m_err);
            check(rdata, e.exp_rdata, $sformatf("entry %0d rdata", i));
            check(32'(err), 32'(e.exp_err), $sformatf("entry %0d err", i));
            check(rdata, m_rdata, $sformatf("entry %0d rdata against model", i));
        end

        for (int n = 0; n < NUM_PAIRS; n++) begin
            addr = $random(seed) & ((2**BYTE_AW) - 4);
            imm = $random(seed) & 32'hffc; // Word-aligned offset.
            imm = {{20{imm[11]}}, imm[11:0]};
            data = $random(seed);
            run_transaction(store_inst(F3_SW, imm[11:0]), addr - imm, data, n % 3,
                            rdata, err);
            model_access(store_inst(F3_SW, imm[11:0]), addr - imm, data, m_rdata, m_err);
            check(32'(err), 32'(m_err), $sformatf("random store %0d err", n));
            check(rdata, 32'h0, $sformatf("random store %0d rdata", n));
            run_transaction(load_inst(F3_LW, imm[11:0]), addr - imm, 32'h0, n % 2,
                            rdata, err);
            model_access(load_inst(F3_LW, imm[11:0]), addr - imm, 32'h0, m_rdata, m_err);
            check(32'(err), 32'(m_err), $sformatf("random load %0d err", n));
            check(rdata, m_rdata, $sformatf("random load %0d rdata", n));
            check(rdata, data, $sformatf("random load %0d readback", n));
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  en,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  lsu_pkg::ram_write_t   wr,
    output logic [31:0]           rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [31:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr.wmask[b]) begin
                        mem[addr][8*b +: 8] <= wr.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata <= mem[addr]; // One-cycle read.
            end
        end
    end

endmodule

// ==== verilog/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  lsu_pkg::mem_access_t access,
    input  logic [31:0]          raw,
    output logic [31:0]          data
);

    import lsu_pkg::*;

    logic [31:0] shifted;

    // Addressed byte down to lane 0.
    assign shifted = raw >> {access.byte_off, 3'b000};

    always_comb begin
        case (access.size)
            SIZE_BYTE: begin
                if (access.sign_ext) begin
                    data = {{24{shifted[7]}}, shifted[7:0]};
                end else begin
                    data = {24'b0, shifted[7:0]};
                end
            end
            SIZE_HALF: begin
                if (access.sign_ext) begin
                    data = {{16{shifted[15]}}, shifted[15:0]};
                end else begin
                    data = {16'b0, shifted[15:0]};
                end
            end
            default: data = shifted;
        endcase
    end

endmodule

// ==== verilog/lsu_ctrl.sv ====
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  lsu_pkg::lsu_req_t    request,
    output logic                 ack,
    output lsu_pkg::lsu_req_t    latched,
    input  lsu_pkg::mem_access_t access,
    output logic                 mem_strobe,
    output logic                 mem_we,
    input  logic [31:0]          load_data,
    output lsu_pkg::lsu_rsp_t    response
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND
    } state_t;

    state_t state;

    // RAM is touched for one cycle, and only for a valid access.
    assign mem_strobe = (state == ST_ACCESS) && !access.err;
    assign mem_we = mem_strobe && access.is_store;

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            latched <= request;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            ack <= 1'b0;
            response <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    state <= ST_RESPOND; // Read word lands this edge.
                end
                ST_RESPOND: begin
                    if (!ack) begin
                        ack <= 1'b1;
                        response.err <= access.err;
                        if (access.is_load && !access.err) begin
                            response.rdata <= load_data;
                        end else begin
                            response.rdata <= 32'b0;
                        end
                    end else if (!req) begin
                        // Requester released, close the handshake.
                        ack <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/lsu_decode.sv ====
`timescale 1ns/1ps

module lsu_decode (
    input  lsu_pkg::lsu_req_t    latched,
    output lsu_pkg::mem_access_t access
);

    import lsu_pkg::*;
    import rv_isa_pkg::*;

    logic [31:0] imm;
    logic [31:0] eff_addr;

    // S-type immediate for stores, I-type for everything else.
    assign imm = (latched.inst.s.opcode == OP_STORE)
               ? {{20{latched.inst.s.imm_hi[6]}}, latched.inst.s.imm_hi, latched.inst.s.imm_lo}
               : {{20{latched.inst.i.imm[11]}}, latched.inst.i.imm};

    assign eff_addr = latched.base + imm;

    always_comb begin
        logic bad_op;
        bad_op = 1'b0;
        access = '0;
        access.size = SIZE_WORD;
        access.byte_off = eff_addr[1:0];
        access.word_addr = eff_addr[31:2];
        case (latched.inst.i.opcode)
            OP_LOAD: begin
                access.is_load = 1'b1;
                case (latched.inst.i.funct3)
                    F3_LB: begin
                        access.size = SIZE_BYTE;
                        access.sign_ext = 1'b1;
                    end
                    F3_LH: begin
                        access.size = SIZE_HALF;
                        access.sign_ext = 1'b1;
                    end
                    F3_LW:  access.size = SIZE_WORD;
                    F3_LBU: access.size = SIZE_BYTE;
                    F3_LHU: access.size = SIZE_HALF;
                    default: bad_op = 1'b1;
                endcase
            end
            OP_STORE: begin
                access.is_store = 1'b1;
                case (latched.inst.s.funct3)
                    F3_SB: access.size = SIZE_BYTE;
                    F3_SH: access.size = SIZE_HALF;
                    F3_SW: access.size = SIZE_WORD;
                    default: bad_op = 1'b1;
                endcase
            end
            default: bad_op = 1'b1;
        endcase
        access.err = bad_op
                   || (access.size == SIZE_HALF && eff_addr[0])
                   || (access.size == SIZE_WORD && eff_addr[1:0] != 2'b00);
    end

endmodule

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    // One request as handed over by the requester.
    typedef struct packed {
        rv_isa_pkg::rv_inst_u inst;
        logic [31:0]          base;
        logic [31:0]          store_data;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } lsu_rsp_t;

    // Decoded access.
    typedef struct packed {
        logic         is_load;
        logic         is_store;
        logic         sign_ext;
        access_size_t size;
        logic [1:0]   byte_off;
        logic [29:0]  word_addr; // Byte address >> 2.
        logic         err;
    } mem_access_t;

    typedef struct packed {
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } ram_write_t;

endpackage

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  lsu_pkg::lsu_req_t request,
    output logic              ack,
    output lsu_pkg::lsu_rsp_t response
);

    import lsu_pkg::*;

    lsu_req_t    latched;
    mem_access_t access;
    ram_write_t  wr;
    logic        mem_strobe;
    logic        mem_we;
    logic [31:0] ram_rdata;
    logic [31:0] load_data;

    lsu_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .request    (request),
        .ack        (ack),
        .latched    (latched),
        .access     (access),
        .mem_strobe (mem_strobe),
        .mem_we     (mem_we),
        .load_data  (load_data),
        .response   (response)
    );

    lsu_decode u_decode (
        .latched (latched),
        .access  (access)
    );

    store_align u_store_align (
        .access     (access),
        .store_data (latched.store_data),
        .wr         (wr)
    );

    // Memory depth wraps on the low word address bits.
    data_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk   (clk),
        .en    (mem_strobe),
        .we    (mem_we),
        .addr  (access.word_addr[ADDR_WIDTH-1:0]),
        .wr    (wr),
        .rdata (ram_rdata)
    );

    load_align u_load_align (
        .access (access),
        .raw    (ram_rdata),
        .data   (load_data)
    );

endmodule

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes of the memory path, other encodings pass through.
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_t;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // Loads.
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_type_t;

    // Stores, immediate split around rs2/rs1.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_type_t;

    // Same 32-bit word, two field layouts.
    typedef union packed {
        i_type_t i;
        s_type_t s;
    } rv_inst_u;

endpackage

// ==== verilog/store_align.sv ====
`timescale 1ns/1ps

module store_align (
    input  lsu_pkg::mem_access_t access,
    input  logic [31:0]          store_data,
    output lsu_pkg::ram_write_t  wr
);

    import lsu_pkg::*;

    logic [3:0] base_mask;

    always_comb begin
        case (access.size)
            SIZE_BYTE: base_mask = 4'b0001;
            SIZE_HALF: base_mask = 4'b0011;
            default:   base_mask = 4'b1111;
        endcase
    end

    // Lane placement by byte offset.
    assign wr.wmask = base_mask << access.byte_off;
    assign wr.wdata = store_data << {access.byte_off, 3'b000};

endmodule
